//--- compile.f
+incdir+.
dsp_pkg.sv
dsp_cfg_regs.sv
sample_delay_line.sv
ffe_slicer.sv
channel_error.sv
dsp_datapath_top.sv
tb_dsp_datapath.sv

//--- Makefile
TOP = tb_dsp_datapath

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -qx "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_dsp_datapath.sv
`include "dsp_config.svh"

module tb_dsp_datapath;
    timeunit 1ns;
    timeprecision 100ps;
    import dsp_pkg::*;

    localparam int clk_period  = 40;
    localparam int n_words     = 200;
    localparam int n_bus_ops   = 80;
    localparam int watchdog_ns = (3 * n_words * 2 + n_bus_ops * 10 + 20) * clk_period * 2;

    logic        clk;
    logic        reset_i;
    axil_req_t   req;
    axil_rsp_t   rsp;
    lane_codes_t adc_codes_i;
    logic        adc_valid_i;
    lane_bits_t  bits_o;
    lane_errs_t  errs_o;
    logic        out_valid_o;

    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          n_tests = 0;
    int          errors_at_start;
    int          cycle = 0;
    string       test_name = "reset";
    // Register values in address order, as the model sees them
    int          cfg_val[9];
    int          code_hist[2];
    logic        bit_hist[2];
    logic [51:0] exp_q[$];
    int          due_q[$];

    dsp_datapath_top UUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .axil_req_i  (req),
        .axil_rsp_o  (rsp),
        .adc_codes_i (adc_codes_i),
        .adc_valid_i (adc_valid_i),
        .bits_o      (bits_o),
        .errs_o      (errs_o),
        .out_valid_o (out_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not complete within %0d ns", watchdog_ns);
        $display("Testbench failed");
        $finish;
    end

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    // Outputs settle after the rising edge
    always @(negedge clk) begin
        if (!reset_i && out_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output word in %s with no input word behind it", test_name);
            end else begin
                check("bits and errors", 64'(exp_q.pop_front()), 64'({bits_o, errs_o}));
                check("latency", 64'(due_q.pop_front()), 64'(cycle));
            end
        end
    end

    function automatic logic rsp_flag(input int sel);
        case (sel)
            0: return rsp.aw_ready;
            1: return rsp.ar_ready;
            2: return rsp.b_valid;
            default: return rsp.r_valid;
        endcase
    endfunction

    task automatic wait_for(input int sel, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!rsp_flag(sel) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!rsp_flag(sel)) begin
            errors++;
            $display("Bus handshake stalled in %s waiting for %s", test_name, what);
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axil_resp_t resp);
        @(posedge clk);
        #2;
        req.aw_addr  = addr;
        req.aw_valid = 1'b1;
        req.w_data   = data;
        req.w_strb   = 4'hf;
        req.w_valid  = 1'b1;
        wait_for(0, "AW ready");
        check("W ready", 64'(1), 64'(rsp.w_ready));
        @(posedge clk);
        #2;
        req.aw_valid = 1'b0;
        req.w_valid  = 1'b0;
        wait_for(2, "B valid");
        resp = rsp.b_resp;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        @(posedge clk);
        #2;
        req.ar_addr  = addr;
        req.ar_valid = 1'b1;
        wait_for(1, "AR ready");
        @(posedge clk);
        #2;
        req.ar_valid = 1'b0;
        wait_for(3, "R valid");
        data = rsp.r_data;
        resp = rsp.r_resp;
    endtask

    // First write's B is stalled while a second write waits behind it
    task automatic write_during_b_stall(input axil_addr_t addr1, input axil_data_t data1,
                                        input axil_addr_t addr2, input axil_data_t data2,
                                        input int hold);
        @(posedge clk);
        #2;
        req.b_ready  = 1'b0;
        req.aw_addr  = addr1;
        req.w_data   = data1;
        req.w_strb   = 4'hf;
        req.aw_valid = 1'b1;
        req.w_valid  = 1'b1;
        wait_for(0, "AW ready");
        @(posedge clk);
        #2;
        req.aw_addr = addr2;
        req.w_data  = data2;
        wait_for(2, "B valid");
        check("first write response", 64'(axil_resp_okay), 64'(rsp.b_resp));
        for (int n = 0; n < hold; n++) begin
            check("B valid held", 64'(1), 64'(rsp.b_valid));
            check("B response held", 64'(axil_resp_okay), 64'(rsp.b_resp));
            check("second write blocked", 64'(0), 64'(rsp.aw_ready));
            check("second W blocked", 64'(0), 64'(rsp.w_ready));
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req.b_ready = 1'b1;
        wait_for(0, "second AW ready");
        check("second W ready", 64'(1), 64'(rsp.w_ready));
        @(posedge clk);
        #2;
        req.aw_valid = 1'b0;
        req.w_valid  = 1'b0;
        wait_for(2, "second B valid");
        check("second write response", 64'(axil_resp_okay), 64'(rsp.b_resp));
    endtask

    function automatic int field_mask(input int i);
        if (i == 3 || i == 8) begin
            return 'hf;
        end
        return (i == 4) ? 'hfff : 'hff;
    endfunction

    task automatic write_all_regs();
        axil_resp_t r;
        for (int i = 0; i < 9; i++) begin
            axil_write(8'(i * 4), 32'(cfg_val[i]), r);
            check("write response", 64'(axil_resp_okay), 64'(r));
        end
    endtask

    task automatic verify_all_regs();
        axil_data_t d;
        axil_resp_t r;
        for (int i = 0; i < 9; i++) begin
            axil_read(8'(i * 4), d, r);
            check("readback", 64'(cfg_val[i] & field_mask(i)), 64'(d));
            check("read response", 64'(axil_resp_okay), 64'(r));
        end
    endtask

    // Samples x[0..1] and b[0..1] are the tail of the previous valid word
    task automatic model_word(input lane_codes_t codes);
        int         x[6];
        logic       b[6];
        int         acc;
        eq_t        eq;
        lane_bits_t bits;
        lane_errs_t errs;
        x[0] = code_hist[0];
        x[1] = code_hist[1];
        b[0] = bit_hist[0];
        b[1] = bit_hist[1];
        for (int l = 0; l < 4; l++) begin
            x[l+2] = int'(codes[l]);
            acc = 0;
            for (int k = 0; k < 3; k++) begin
                acc += cfg_val[k] * x[l+2-k];
            end
            eq      = eq_t'(acc >>> cfg_val[3]);
            bits[l] = (int'(eq) >= cfg_val[4]);
            b[l+2]  = bits[l];
            acc = 0;
            for (int j = 0; j < 3; j++) begin
                acc += b[l+2-j] ? cfg_val[5+j] : -cfg_val[5+j];
            end
            errs[l] = err_t'((acc >>> cfg_val[8]) - x[l+2]);
        end
        code_hist = '{x[4], x[5]};
        bit_hist  = '{b[4], b[5]};
        exp_q.push_back({bits, errs});
        due_q.push_back(cycle + 2);
    endtask

    task automatic drive_words(input int n, input bit gaps);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(posedge clk);
            #2;
            for (int l = 0; l < 4; l++) begin
                adc_codes_i[l] = code_t'($random(seed));
            end
            adc_valid_i = gaps ? (($random(seed) & 3) != 0) : 1'b1;
            if (adc_valid_i) begin
                model_word(adc_codes_i);
                sent++;
            end
        end
        @(posedge clk);
        #2;
        adc_valid_i = 1'b0;
        for (int i = 0; i < 10 && exp_q.size() != 0; i++) begin
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("No output for %0d words in %s", exp_q.size(), test_name);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        n_tests++;
        $display("%-28s %s, %0d errors", test_name,
                 (errors == errors_at_start) ? "ok" : "FAILED", errors - errors_at_start);
    endtask

    task automatic test_reset_readback();
        start_test("reset values and readback");
        verify_all_regs();
        for (int i = 0; i < 9; i++) begin
            cfg_val[i] = 'h7e5 + i * 'h113;
        end
        write_all_regs();
        verify_all_regs();
        end_test();
    endtask

    task automatic test_unmapped();
        axil_data_t d;
        axil_resp_t r;
        start_test("unmapped access");
        axil_write(8'h40, 32'hffff_ffff, r);
        check("write response", 64'(axil_resp_slverr), 64'(r));
        axil_read(8'h40, d, r);
        check("read response", 64'(axil_resp_slverr), 64'(r));
        check("read data", 64'(0), 64'(d));
        verify_all_regs();
        end_test();
    endtask

    task automatic test_datapath(input string name, input bit gaps);
        start_test(name);
        write_all_regs();
        drive_words(n_words, gaps);
        end_test();
    endtask

    task automatic test_b_backpressure();
        start_test("response back-pressure");
        write_during_b_stall(`DSP_REG_FFE_W1, 32'h33, `DSP_REG_CHAN_T2, 32'h4c, 6);
        cfg_val[1] = 'h33;
        cfg_val[7] = 'h4c;
        verify_all_regs();
        end_test();
    endtask

    initial begin
        seed        = 82923;
        req         = '0;
        req.b_ready = 1'b1;
        req.r_ready = 1'b1;
        adc_codes_i = '0;
        adc_valid_i = 1'b0;
        reset_i     = 1'b1;
        cfg_val     = '{64, 0, 0, 6, 0, 0, 0, 0, 0};
        code_hist   = '{0, 0};
        bit_hist    = '{1'b0, 1'b0};
        repeat (5) @(posedge clk);
        #2;
        reset_i = 1'b0;
        test_reset_readback();
        test_unmapped();
        cfg_val = '{64, 0, 0, 6, 0, 0, 0, 0, 0};
        test_datapath("identity path", 1'b0);
        // Taps reach back into the previous word, threshold below zero
        cfg_val = '{40, -12, 6, 5, -20, 0, 0, 0, 0};
        test_datapath("equalizer and threshold", 1'b1);
        cfg_val = '{40, -12, 6, 5, -20, 90, -30, 12, 2};
        test_datapath("channel filter and error", 1'b0);
        test_b_backpressure();
        $display("Tests run: %0d, checks: %0d, errors: %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- dsp_datapath_top.sv
module dsp_datapath_top (
    input  logic                 clk,
    input  logic                 reset_i,
    input  dsp_pkg::axil_req_t   axil_req_i,
    output dsp_pkg::axil_rsp_t   axil_rsp_o,
    input  dsp_pkg::lane_codes_t adc_codes_i,
    input  logic                 adc_valid_i,
    output dsp_pkg::lane_bits_t  bits_o,
    output dsp_pkg::lane_errs_t  errs_o,
    output logic                 out_valid_o
);
    import dsp_pkg::*;

    dsp_cfg_t    cfg;
    lane_codes_t codes_d1;
    lane_bits_t  ffe_bits;
    logic        valid_d1;

    dsp_cfg_regs cfg_regs_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .axil_req_i (axil_req_i),
        .axil_rsp_o (axil_rsp_o),
        .cfg_o      (cfg)
    );

    // Codes meet the sliced bits of the same word
    sample_delay_line #(
        .payload_t (lane_codes_t),
        .DEPTH     (1)
    ) code_dly_i (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (adc_codes_i),
        .data_o  (codes_d1)
    );

    sample_delay_line #(
        .payload_t (logic),
        .DEPTH     (1)
    ) valid_dly1_i (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (adc_valid_i),
        .data_o  (valid_d1)
    );

    sample_delay_line #(
        .payload_t (logic),
        .DEPTH     (1)
    ) valid_dly2_i (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (valid_d1),
        .data_o  (out_valid_o)
    );

    ffe_slicer ffe_i (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg_i   (cfg),
        .codes_i (adc_codes_i),
        .valid_i (adc_valid_i),
        .bits_o  (ffe_bits)
    );

    channel_error chan_err_i (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg_i   (cfg),
        .bits_i  (ffe_bits),
        .valid_i (valid_d1),
        .codes_i (codes_d1),
        .errs_o  (errs_o)
    );

    // Bits wait one cycle for their errors
    sample_delay_line #(
        .payload_t (lane_bits_t),
        .DEPTH     (1)
    ) bits_dly_i (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (ffe_bits),
        .data_o  (bits_o)
    );

endmodule

//--- channel_error.sv
`include "dsp_config.svh"

module channel_error (
    input  logic                 clk,
    input  logic                 reset_i,
    input  dsp_pkg::dsp_cfg_t    cfg_i,
    input  dsp_pkg::lane_bits_t  bits_i,
    input  logic                 valid_i,
    input  dsp_pkg::lane_codes_t codes_i,
    output dsp_pkg::lane_errs_t  errs_o
);
    import dsp_pkg::*;

    localparam int n_lanes  = `DSP_LANES;
    localparam int n_taps   = `DSP_CHAN_TAPS;
    localparam int n_hist   = n_taps - 1;
    localparam int acc_bits = `DSP_COEF_BITS + $clog2(n_taps);

    typedef logic signed [acc_bits-1:0] acc_t;

    logic [n_hist-1:0]         bhist_q;
    logic [n_lanes+n_hist-1:0] span;
    lane_errs_t                errs_d;
    lane_errs_t                errs_q;

    assign span = {bits_i, bhist_q};

    always_comb begin
        acc_t  acc;
        acc_t  tap;
        err_t  est;
        err_t  code;
        errs_d = '0;
        for (int l = 0; l < n_lanes; l++) begin
            acc = '0;
            // Bit 1 maps to +1, bit 0 to -1
            for (int j = 0; j < n_taps; j++) begin
                tap = acc_t'(cfg_i.chan_tap[j]);
                if (span[l + n_hist - j]) begin
                    acc = acc + tap;
                end else begin
                    acc = acc - tap;
                end
            end
            est       = err_t'(acc >>> cfg_i.chan_shift);
            code      = err_t'(codes_i[l]);
            errs_d[l] = est - code;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bhist_q <= '0;
            errs_q  <= '0;
        end else begin
            errs_q <= errs_d;
            if (valid_i) begin
                bhist_q <= bits_i[n_lanes-1 -: n_hist];
            end
        end
    end

    assign errs_o = errs_q;

endmodule

//--- ffe_slicer.sv
`include "dsp_config.svh"

module ffe_slicer (
    input  logic                 clk,
    input  logic                 reset_i,
    input  dsp_pkg::dsp_cfg_t    cfg_i,
    input  dsp_pkg::lane_codes_t codes_i,
    input  logic                 valid_i,
    output dsp_pkg::lane_bits_t  bits_o
);
    import dsp_pkg::*;

    localparam int n_lanes  = `DSP_LANES;
    localparam int n_taps   = `DSP_FFE_TAPS;
    localparam int n_hist   = n_taps - 1;
    localparam int acc_bits = `DSP_CODE_BITS + `DSP_COEF_BITS + $clog2(n_taps);

    typedef logic signed [acc_bits-1:0] acc_t;

    // Last lanes of the previous valid word, index 0 oldest
    code_t [n_hist-1:0]         hist_q;
    code_t [n_lanes+n_hist-1:0] span;
    lane_bits_t                 bits_d;
    lane_bits_t                 bits_q;

    // Samples in time order across the word boundary
    assign span = {codes_i, hist_q};

    always_comb begin
        acc_t  acc;
        acc_t  prod;
        coef_t w;
        code_t x;
        eq_t   eq;
        eq_t   thr;
        thr    = cfg_i.thresh;
        bits_d = '0;
        for (int l = 0; l < n_lanes; l++) begin
            acc = '0;
            for (int k = 0; k < n_taps; k++) begin
                w    = cfg_i.ffe_w[k];
                x    = span[l + n_hist - k];
                prod = acc_t'(w) * acc_t'(x);
                acc  = acc + prod;
            end
            // Wraps to the equalized width after the shift
            eq        = eq_t'(acc >>> cfg_i.ffe_shift);
            bits_d[l] = (eq >= thr);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hist_q <= '0;
            bits_q <= '0;
        end else begin
            bits_q <= bits_d;
            if (valid_i) begin
                hist_q <= codes_i[n_lanes-1 -: n_hist];
            end
        end
    end

    assign bits_o = bits_q;

endmodule

//--- sample_delay_line.sv
module sample_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     reset_i,
    input  payload_t data_i,
    output payload_t data_o
);

    // Stage 0 is the newest entry
    payload_t stage_q [DEPTH];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign data_o = stage_q[DEPTH-1];

endmodule

//--- dsp_cfg_regs.sv
`include "dsp_config.svh"

module dsp_cfg_regs (
    input  logic               clk,
    input  logic               reset_i,
    input  dsp_pkg::axil_req_t axil_req_i,
    output dsp_pkg::axil_rsp_t axil_rsp_o,
    output dsp_pkg::dsp_cfg_t  cfg_o
);
    import dsp_pkg::*;

    localparam dsp_cfg_t cfg_reset = '{
        ffe_w:      {coef_t'(0), coef_t'(0), coef_t'(`DSP_RST_FFE_W0)},
        ffe_shift:  shift_t'(`DSP_RST_FFE_SHIFT),
        thresh:     '0,
        chan_tap:   '0,
        chan_shift: '0
    };

    dsp_cfg_t   cfg_q;
    logic       wr_fire;
    logic       rd_fire;
    logic       b_valid_q;
    axil_resp_t b_resp_q;
    logic       r_valid_q;
    axil_data_t r_data_q;
    axil_resp_t r_resp_q;
    axil_data_t rd_word;

    function automatic logic addr_mapped(input axil_addr_t addr);
        case (addr)
            `DSP_REG_FFE_W0, `DSP_REG_FFE_W1, `DSP_REG_FFE_W2,
            `DSP_REG_FFE_SHIFT, `DSP_REG_THRESH,
            `DSP_REG_CHAN_T0, `DSP_REG_CHAN_T1, `DSP_REG_CHAN_T2,
            `DSP_REG_CHAN_SHIFT: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    // Only the two low byte lanes reach a register
    function automatic logic [15:0] merge16(input logic [15:0] cur, input axil_data_t wdata,
                                            input axil_strb_t strb);
        logic [15:0] res;
        res = cur;
        if (strb[0]) begin
            res[7:0] = wdata[7:0];
        end
        if (strb[1]) begin
            res[15:8] = wdata[15:8];
        end
        return res;
    endfunction

    // One write in flight until its response is taken
    assign wr_fire = axil_req_i.aw_valid & axil_req_i.w_valid & ~b_valid_q;
    assign rd_fire = axil_req_i.ar_valid & ~r_valid_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q <= cfg_reset;
        end else if (wr_fire) begin
            case (axil_req_i.aw_addr)
                `DSP_REG_FFE_W0: cfg_q.ffe_w[0] <= coef_t'(merge16(16'(cfg_q.ffe_w[0]),
                    axil_req_i.w_data, axil_req_i.w_strb));
                `DSP_REG_FFE_W1: cfg_q.ffe_w[1] <= coef_t'(merge16(16'(cfg_q.ffe_w[1]),
                    axil_req_i.w_data, axil_req_i.w_strb));
                `DSP_REG_FFE_W2: cfg_q.ffe_w[2] <= coef_t'(merge16(16'(cfg_q.ffe_w[2]),
                    axil_req_i.w_data, axil_req_i.w_strb));
                `DSP_REG_FFE_SHIFT: cfg_q.ffe_shift <= shift_t'(merge16(16'(cfg_q.ffe_shift),
                    axil_req_i.w_data, axil_req_i.w_strb));
                `DSP_REG_THRESH: cfg_q.thresh <= eq_t'(merge16(16'(cfg_q.thresh),
                    axil_req_i.w_data, axil_req_i.w_strb));
                `DSP_REG_CHAN_T0: cfg_q.chan_tap[0] <= coef_t'(merge16(16'(cfg_q.chan_tap[0]),
                    axil_req_i.w_data, axil_req_i.w_strb));
                `DSP_REG_CHAN_T1: cfg_q.chan_tap[1] <= coef_t'(merge16(16'(cfg_q.chan_tap[1]),
                    axil_req_i.w_data, axil_req_i.w_strb));
                `DSP_REG_CHAN_T2: cfg_q.chan_tap[2] <= coef_t'(merge16(16'(cfg_q.chan_tap[2]),
                    axil_req_i.w_data, axil_req_i.w_strb));
                `DSP_REG_CHAN_SHIFT: cfg_q.chan_shift <= shift_t'(merge16(16'(cfg_q.chan_shift),
                    axil_req_i.w_data, axil_req_i.w_strb));
                default: cfg_q <= cfg_q;
            endcase
        end
    end

    // Readback is zero extended to the bus width
    always_comb begin
        case (axil_req_i.ar_addr)
            `DSP_REG_FFE_W0:     rd_word = axil_data_t'(unsigned'(cfg_q.ffe_w[0]));
            `DSP_REG_FFE_W1:     rd_word = axil_data_t'(unsigned'(cfg_q.ffe_w[1]));
            `DSP_REG_FFE_W2:     rd_word = axil_data_t'(unsigned'(cfg_q.ffe_w[2]));
            `DSP_REG_FFE_SHIFT:  rd_word = axil_data_t'(cfg_q.ffe_shift);
            `DSP_REG_THRESH:     rd_word = axil_data_t'(unsigned'(cfg_q.thresh));
            `DSP_REG_CHAN_T0:    rd_word = axil_data_t'(unsigned'(cfg_q.chan_tap[0]));
            `DSP_REG_CHAN_T1:    rd_word = axil_data_t'(unsigned'(cfg_q.chan_tap[1]));
            `DSP_REG_CHAN_T2:    rd_word = axil_data_t'(unsigned'(cfg_q.chan_tap[2]));
            `DSP_REG_CHAN_SHIFT: rd_word = axil_data_t'(cfg_q.chan_shift);
            default:             rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (wr_fire) begin
                b_valid_q <= 1'b1;
            end else if (axil_req_i.b_ready) begin
                b_valid_q <= 1'b0;
            end
            if (rd_fire) begin
                r_valid_q <= 1'b1;
            end else if (axil_req_i.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            b_resp_q <= addr_mapped(axil_req_i.aw_addr) ? axil_resp_okay : axil_resp_slverr;
        end
        if (rd_fire) begin
            r_data_q <= rd_word;
            r_resp_q <= addr_mapped(axil_req_i.ar_addr) ? axil_resp_okay : axil_resp_slverr;
        end
    end

    always_comb begin
        axil_rsp_o.aw_ready = wr_fire;
        axil_rsp_o.w_ready  = wr_fire;
        axil_rsp_o.b_valid  = b_valid_q;
        axil_rsp_o.b_resp   = b_resp_q;
        axil_rsp_o.ar_ready = rd_fire;
        axil_rsp_o.r_valid  = r_valid_q;
        axil_rsp_o.r_data   = r_data_q;
        axil_rsp_o.r_resp   = r_resp_q;
    end

    assign cfg_o = cfg_q;

endmodule

//--- dsp_pkg.sv
`include "dsp_config.svh"

package dsp_pkg;

    typedef logic signed [`DSP_CODE_BITS-1:0]  code_t;
    typedef logic signed [`DSP_EQ_BITS-1:0]    eq_t;
    typedef logic signed [`DSP_ERR_BITS-1:0]   err_t;
    typedef logic signed [`DSP_COEF_BITS-1:0]  coef_t;
    typedef logic        [`DSP_SHIFT_BITS-1:0] shift_t;

    // Lane 0 is the earliest sample of the word
    typedef code_t [`DSP_LANES-1:0] lane_codes_t;
    typedef logic  [`DSP_LANES-1:0] lane_bits_t;
    typedef err_t  [`DSP_LANES-1:0] lane_errs_t;

    typedef struct packed {
        coef_t [`DSP_FFE_TAPS-1:0]  ffe_w;
        shift_t                     ffe_shift;
        eq_t                        thresh;
        coef_t [`DSP_CHAN_TAPS-1:0] chan_tap;
        shift_t                     chan_shift;
    } dsp_cfg_t;

    typedef logic [`DSP_AXIL_ADDR_BITS-1:0]   axil_addr_t;
    typedef logic [`DSP_AXIL_DATA_BITS-1:0]   axil_data_t;
    typedef logic [`DSP_AXIL_DATA_BITS/8-1:0] axil_strb_t;
    typedef logic [1:0]                       axil_resp_t;

    localparam axil_resp_t axil_resp_okay   = 2'b00;
    localparam axil_resp_t axil_resp_slverr = 2'b10;

    typedef struct packed {
        axil_addr_t aw_addr;
        logic       aw_valid;
        axil_data_t w_data;
        axil_strb_t w_strb;
        logic       w_valid;
        logic       b_ready;
        axil_addr_t ar_addr;
        logic       ar_valid;
        logic       r_ready;
    } axil_req_t;

    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        axil_resp_t b_resp;
        logic       ar_ready;
        logic       r_valid;
        axil_data_t r_data;
        axil_resp_t r_resp;
    } axil_rsp_t;

endpackage

//--- dsp_config.svh
`ifndef DSP_CONFIG_SVH
`define DSP_CONFIG_SVH

// Datapath geometry
`define DSP_LANES       4
`define DSP_CODE_BITS   8
`define DSP_EQ_BITS     12
`define DSP_ERR_BITS    12
`define DSP_COEF_BITS   8
`define DSP_SHIFT_BITS  4
`define DSP_FFE_TAPS    3
`define DSP_CHAN_TAPS   3

// AXI4-Lite bus
`define DSP_AXIL_ADDR_BITS 8
`define DSP_AXIL_DATA_BITS 32

// Register map
`define DSP_REG_FFE_W0     8'h00
`define DSP_REG_FFE_W1     8'h04
`define DSP_REG_FFE_W2     8'h08
`define DSP_REG_FFE_SHIFT  8'h0C
`define DSP_REG_THRESH     8'h10
`define DSP_REG_CHAN_T0    8'h14
`define DSP_REG_CHAN_T1    8'h18
`define DSP_REG_CHAN_T2    8'h1C
`define DSP_REG_CHAN_SHIFT 8'h20

// Identity equalizer out of reset
`define DSP_RST_FFE_W0     64
`define DSP_RST_FFE_SHIFT  6

`endif
